// ==== rtl/jag_mem_pkg.sv ====
/* shared widths, load base, sequencer states and port types for the console to DDR bridge
   imported by every RTL module of the bridge and by the testbench */
package jag_mem_pkg;

	// ========================================================================
	// widths and constants
	// ========================================================================
	localparam int ddr_addr_w  = 29;	// DDR word address
	localparam int ddr_data_w  = 64;	// one DDR word
	localparam int ddr_be_w    = 8;	// byte lanes
	localparam int cart_addr_w = 24;	// cartridge byte address
	localparam int load_addr_w = 32;	// loader byte counter

	// ROM image lands here in DDR (byte address)
	localparam logic [load_addr_w-1:0] load_base_addr = 32'h0080_0000;

	// sequencer states, read path low, write path high, done all ones
	typedef enum logic [3:0] {
		idle     = 4'b0000,
		rd_req   = 4'b0001,	// rd held until DDR not busy
		rd_wait  = 4'b0010,	// wait dout_ready
		wr_latch = 4'b1001,	// grab core data and enables
		wr_req   = 4'b1010,	// we held until DDR not busy
		wr_hold1 = 4'b1011,
		wr_hold2 = 4'b1100,
		wr_hold3 = 4'b1101,
		done     = 4'b1111	// ram_rdy, wait for cas_n
	} seq_state_t;

	// one DDR word, seen as bytes (byte 0 at the top) or as 16-bit halves
	typedef union packed {
		logic [0:7][7:0]  b;	// cartridge byte select
		logic [0:3][15:0] h;	// loader replication
	} ddr_word_u;

	// console DRAM strobes, all active low except fdram
	typedef struct packed {
		logic [3:0] oe_n;
		logic [3:0] uw_n;
		logic [3:0] lw_n;
		logic       cas_n;
		logic       fdram;	// high = DRAM cycle, low = cartridge cycle
	} core_dram_t;

	// cartridge strobes
	typedef struct packed {
		logic [cart_addr_w-1:0] addr;
		logic                   ce_n;
		logic [1:0]             oe_n;
	} cart_bus_t;

	// download stream from the host
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [15:0] data;
	} load_in_t;

	// one loader write towards DDR
	typedef struct packed {
		logic                   en;	// loader owns DDR
		logic                   wr;
		logic [load_addr_w-1:0] addr;	// byte address
		logic [ddr_be_w-1:0]    be;
		ddr_word_u              data;
	} load_wr_t;

	// DDR command side
	typedef struct packed {
		logic [ddr_addr_w-1:0] addr;
		logic                  rd;
		logic                  we;
		logic [ddr_data_w-1:0] din;
		logic [ddr_be_w-1:0]   be;
	} ddr_cmd_t;

	// DDR response side
	typedef struct packed {
		logic      busy;
		logic      dout_ready;
		ddr_word_u dout;
	} ddr_rsp_t;

endpackage

// ==== rtl/rom_loader.sv ====
/* ROM loader: turns 16-bit download strobes into DDR word writes from load_base_addr
   and keeps the console in reset while an image is loading */
`timescale 1ns/100ps

module rom_loader import jag_mem_pkg::*; (
	input  logic     SYS_CLK,
	input  logic     reset,
	input  load_in_t load_in,
	output load_wr_t load_wr,
	output logic     core_hold
);

	logic                   dl_q;	// download, one cycle late
	logic                   dl_active;
	logic                   dl_start;
	logic                   dl_end;
	logic                   start_q;	// one cycle reset pulse on start
	logic                   en_q;
	logic                   wr_q;
	logic [load_addr_w-1:0] addr_q;
	logic [ddr_be_w-1:0]    be;
	ddr_word_u              data_q;
	logic [15:0]            swapped;

	assign dl_active = load_in.download && (load_in.index != 8'd0);
	assign dl_start  = !dl_q && dl_active;	// rising edge, image index only
	assign dl_end    = dl_q && !load_in.download;
	assign swapped   = {load_in.data[7:0], load_in.data[15:8]};	// host sends little end first

	// ========================================================================
	// control: edge detect, write strobe, address counter
	// ========================================================================
	always_ff @(posedge SYS_CLK or posedge reset) begin
		if (reset) begin
			dl_q    <= 1'b0;
			start_q <= 1'b0;
			en_q    <= 1'b0;
			wr_q    <= 1'b0;
			addr_q  <= load_base_addr;
		end else begin
			dl_q    <= load_in.download;
			start_q <= dl_start;
			wr_q    <= load_in.wr && dl_active;	// no back-pressure, every strobe taken

			if (wr_q)
				addr_q <= addr_q + 2'd2;	// one 16-bit word per write
			if (dl_start)
				addr_q <= load_base_addr;	// restart wins over step

			if (load_in.wr && dl_active)
				en_q <= 1'b1;
			if (dl_end)
				en_q <= 1'b0;	// release the port once download drops
		end
	end

	// write data travels with the strobe
	always_ff @(posedge SYS_CLK) begin
		if (load_in.wr && dl_active)
			data_q.h <= {4{swapped}};	// same half on every lane pair
	end

	// lane pair from address bits 2..1, lane 7 is the lowest byte address
	assign be = 8'hc0 >> {addr_q[2:1], 1'b0};

	always_comb begin
		load_wr.en   = en_q;
		load_wr.wr   = wr_q;
		load_wr.addr = addr_q;
		load_wr.be   = be;
		load_wr.data = data_q;
	end

	assign core_hold = en_q | start_q;	// console held for the whole load

endmodule

// ==== rtl/dram_sequencer.sv ====
/* memory sequencer: turns console DRAM strobes and cartridge chip enable into
   single DDR read or write requests and flags completion on ram_rdy */
`timescale 1ns/100ps

module dram_sequencer import jag_mem_pkg::*; (
	input  logic                  SYS_CLK,
	input  logic                  reset,
	input  core_dram_t            core_dram,
	input  logic [ddr_data_w-1:0] core_d,
	input  cart_bus_t             cart,
	input  logic                  ddr_busy,
	input  logic                  ddr_dout_ready,
	output logic                  ram_rdy,
	output logic                  seq_rd,
	output logic                  seq_we,
	output logic [ddr_data_w-1:0] wr_word,
	output logic [ddr_be_w-1:0]   wr_be
);

	seq_state_t state;
	logic       ce_n_q;	// cart ce_n, one cycle late
	logic       ce_fall;
	logic       rd_start;
	logic       wr_start;

	assign ce_fall = ce_n_q && !cart.ce_n;

	// DRAM read on any oe, cartridge read on ce_n falling edge
	assign rd_start = (core_dram.fdram && (core_dram.oe_n != 4'hf)) ||
	                  (!core_dram.fdram && ce_fall);
	assign wr_start = core_dram.fdram && ({core_dram.uw_n, core_dram.lw_n} != 8'hff);

	// ========================================================================
	// state machine
	// ========================================================================
	always_ff @(posedge SYS_CLK or posedge reset) begin
		if (reset) begin
			state  <= idle;
			ce_n_q <= 1'b1;
			seq_rd <= 1'b0;
			seq_we <= 1'b0;
		end else begin
			ce_n_q <= cart.ce_n;

			case (state)
				idle: begin
					if (rd_start) begin	// reads win over writes
						state  <= rd_req;
						seq_rd <= 1'b1;
					end else if (wr_start) begin
						state <= wr_latch;
					end
				end

				rd_req: begin
					if (!ddr_busy) begin	// accepted this cycle
						seq_rd <= 1'b0;
						state  <= rd_wait;
					end
				end

				rd_wait:
					if (ddr_dout_ready)
						state <= done;	// dout valid now, mux passes it through

				wr_latch: begin
					seq_we <= 1'b1;	// word and enables latched below
					state  <= wr_req;
				end

				wr_req: begin
					if (!ddr_busy) begin
						seq_we <= 1'b0;
						state  <= wr_hold1;
					end
				end

				// settle time before the console sees ready
				wr_hold1: state <= wr_hold2;
				wr_hold2: state <= wr_hold3;
				wr_hold3: state <= done;

				done:
					if (core_dram.cas_n)
						state <= idle;	// console closed the cycle

				default: state <= idle;
			endcase
		end
	end

	// write payload, interleaved upper/lower enables per 16-bit lane pair
	always_ff @(posedge SYS_CLK) begin
		if (state == wr_latch) begin
			wr_word <= core_d;
			wr_be   <= ~{core_dram.uw_n[3], core_dram.lw_n[3],
			             core_dram.uw_n[2], core_dram.lw_n[2],
			             core_dram.uw_n[1], core_dram.lw_n[1],
			             core_dram.uw_n[0], core_dram.lw_n[0]};
		end
	end

	assign ram_rdy = (state == done);

endmodule

// ==== rtl/ddr_port_mux.sv ====
/* DDR port mux: hands the DDR port to the loader during a load and to the console otherwise,
   and decodes returned words for cartridge and DRAM reads */
`timescale 1ns/100ps

module ddr_port_mux import jag_mem_pkg::*; (
	input  load_wr_t              load_wr,
	input  cart_bus_t             cart,
	input  core_dram_t            core_dram,
	input  logic                  seq_rd,
	input  logic                  seq_we,
	input  logic [ddr_data_w-1:0] wr_word,
	input  logic [ddr_be_w-1:0]   wr_be,
	input  ddr_word_u             ddr_dout,
	output ddr_cmd_t              ddr_cmd,
	output logic [31:0]           cart_q,
	output logic [1:0]            cart_oe,
	output logic [63:0]           dram_q,
	output logic [3:0]            dram_oe
);

	// ========================================================================
	// command side
	// ========================================================================
	always_comb begin
		if (load_wr.en) begin
			// loader owns the port, write only
			ddr_cmd.addr = ddr_addr_w'(load_wr.addr[23:3]);	// byte to word address
			ddr_cmd.rd   = 1'b0;
			ddr_cmd.we   = load_wr.wr;
			ddr_cmd.din  = load_wr.data;
			ddr_cmd.be   = load_wr.be;
		end else begin
			// console side, DRAM also addressed through cart addr
			ddr_cmd.addr = ddr_addr_w'(cart.addr[23:3]);
			ddr_cmd.rd   = seq_rd;
			ddr_cmd.we   = seq_we;
			ddr_cmd.din  = wr_word;
			ddr_cmd.be   = !cart.ce_n ? {ddr_be_w{1'b1}} : wr_be;	// cart reads take full word
		end
	end

	// ========================================================================
	// return side
	// ========================================================================
	// 8-bit cartridge, one byte copied to all four lanes
	assign cart_q  = {4{ddr_dout.b[cart.addr[2:0]]}};
	assign cart_oe = ~cart.oe_n & {2{~cart.ce_n}};

	assign dram_q  = ddr_dout;	// straight bit for bit
	assign dram_oe = !core_dram.cas_n ? ~core_dram.oe_n : 4'b0000;	// only inside a cas cycle

endmodule

// ==== rtl/jag_ddr_bridge.sv ====
/* top of the console to DDR bridge: ROM loader, memory sequencer and port mux
   sit between the console core, the download stream and one 64-bit DDR port */
`timescale 1ns/100ps

module jag_ddr_bridge import jag_mem_pkg::*; (
	input  logic                  SYS_CLK,
	input  logic                  reset,
	input  load_in_t              load_in,
	input  core_dram_t            core_dram,
	input  logic [ddr_data_w-1:0] core_d,
	input  cart_bus_t             cart,
	input  ddr_rsp_t              ddr_rsp,
	output ddr_cmd_t              ddr_cmd,
	output logic                  core_hold,
	output logic                  ram_rdy,
	output logic [31:0]           cart_q,
	output logic [1:0]            cart_oe,
	output logic [63:0]           dram_q,
	output logic [3:0]            dram_oe
);

	load_wr_t              load_wr;	// loader write and ownership
	logic                  seq_rd;
	logic                  seq_we;
	logic [ddr_data_w-1:0] wr_word;	// latched console write
	logic [ddr_be_w-1:0]   wr_be;

	rom_loader u_loader (
		.SYS_CLK   (SYS_CLK),
		.reset     (reset),
		.load_in   (load_in),
		.load_wr   (load_wr),
		.core_hold (core_hold)
	);

	dram_sequencer u_seq (
		.SYS_CLK        (SYS_CLK),
		.reset          (reset),
		.core_dram      (core_dram),
		.core_d         (core_d),
		.cart           (cart),
		.ddr_busy       (ddr_rsp.busy),
		.ddr_dout_ready (ddr_rsp.dout_ready),
		.ram_rdy        (ram_rdy),
		.seq_rd         (seq_rd),
		.seq_we         (seq_we),
		.wr_word        (wr_word),
		.wr_be          (wr_be)
	);

	ddr_port_mux u_mux (
		.load_wr   (load_wr),
		.cart      (cart),
		.core_dram (core_dram),
		.seq_rd    (seq_rd),
		.seq_we    (seq_we),
		.wr_word   (wr_word),
		.wr_be     (wr_be),
		.ddr_dout  (ddr_rsp.dout),
		.ddr_cmd   (ddr_cmd),
		.cart_q    (cart_q),
		.cart_oe   (cart_oe),
		.dram_q    (dram_q),
		.dram_oe   (dram_oe)
	);

endmodule

// ==== verification/ddr_mem_model.sv ====
/* behavioral DDR memory for the bridge testbench, a sparse word store with random busy
   and one dout_ready pulse 1 to 4 cycles after each accepted read */
`timescale 1ns/100ps

module ddr_mem_model import jag_mem_pkg::*; (
	input  logic     SYS_CLK,
	input  logic     reset,
	input  ddr_cmd_t ddr_cmd,
	output ddr_rsp_t ddr_rsp
);

	logic [ddr_data_w-1:0] store [logic [ddr_addr_w-1:0]];	// only touched words
	logic [ddr_addr_w-1:0] rd_addr;
	logic [2:0]            delay;	// cycles left to dout_ready
	logic                  pending;
	integer                seed;

	initial seed = 32'he37fc3d2;

	// unwritten words read back as a pattern of their own address
	function automatic logic [ddr_data_w-1:0] peek(input logic [ddr_addr_w-1:0] a);
		if (store.exists(a))
			return store[a];
		return {3'b000, a, 3'b101, ~a};
	endfunction

	always @(posedge SYS_CLK or posedge reset) begin : mem_seq
		logic [ddr_data_w-1:0] w;
		if (reset) begin
			ddr_rsp <= '0;
			pending <= 1'b0;
			delay   <= 3'd0;
			rd_addr <= '0;
		end else begin
			ddr_rsp.busy       <= ($random(seed) & 1) != 0;	// busy about half the time
			ddr_rsp.dout_ready <= 1'b0;

			// writes land on every we cycle, a held we repeats the same write
			if (ddr_cmd.we) begin
				w = peek(ddr_cmd.addr);
				for (int j = 0; j < ddr_be_w; j++)
					if (ddr_cmd.be[j])
						w[8*j +: 8] = ddr_cmd.din[8*j +: 8];	// lane 7 is the top byte
				store[ddr_cmd.addr] = w;
			end

			if (pending) begin
				if (delay == 3'd1) begin
					ddr_rsp.dout_ready <= 1'b1;
					ddr_rsp.dout       <= peek(rd_addr);	// held until the next read returns
					pending            <= 1'b0;
				end else
					delay <= delay - 3'd1;
			end else if (ddr_cmd.rd && !ddr_rsp.busy) begin
				pending <= 1'b1;	// one read in flight at a time
				rd_addr <= ddr_cmd.addr;
				delay   <= 3'd1 + 3'($random(seed) & 3);	// 1 to 4 cycles
			end
		end
	end

endmodule

// ==== verification/jag_ddr_bridge_tb.sv ====
/* testbench for the console to DDR bridge, loads a ROM image and then runs cartridge reads,
   DRAM writes and DRAM reads against the behavioral DDR model */
`timescale 1ns/100ps

module jag_ddr_bridge_tb import jag_mem_pkg::*; ();

	localparam int n_load = 12;	// download words
	localparam int n_cart = 8;
	localparam int n_wr   = 8;	// each written word is read back once
	localparam int n_xfer = 2 * n_load + n_cart + 2 * n_wr;

	logic                  SYS_CLK;
	logic                  reset;
	load_in_t              load_in;
	core_dram_t            core_dram;
	logic [ddr_data_w-1:0] core_d;
	cart_bus_t             cart;
	ddr_rsp_t              ddr_rsp;
	ddr_cmd_t              ddr_cmd;
	logic                  core_hold;
	logic                  ram_rdy;
	logic [31:0]           cart_q;
	logic [1:0]            cart_oe;
	logic [63:0]           dram_q;
	logic [3:0]            dram_oe;

	integer                seed;
	logic [15:0]           load_words [$];	// as sent on the download stream
	int                    load_seen;
	int                    rd_accepts;
	int                    wr_accepts;
	logic [ddr_addr_w-1:0] exp_addr;	// expected console command
	logic [ddr_be_w-1:0]   exp_be;
	logic [ddr_data_w-1:0] exp_din;

	jag_ddr_bridge UUT (
		.SYS_CLK   (SYS_CLK),
		.reset     (reset),
		.load_in   (load_in),
		.core_dram (core_dram),
		.core_d    (core_d),
		.cart      (cart),
		.ddr_rsp   (ddr_rsp),
		.ddr_cmd   (ddr_cmd),
		.core_hold (core_hold),
		.ram_rdy   (ram_rdy),
		.cart_q    (cart_q),
		.cart_oe   (cart_oe),
		.dram_q    (dram_q),
		.dram_oe   (dram_oe)
	);

	ddr_mem_model mem_model (
		.SYS_CLK (SYS_CLK),
		.reset   (reset),
		.ddr_cmd (ddr_cmd),
		.ddr_rsp (ddr_rsp)
	);

	initial SYS_CLK = 1'b0;
	always #20 SYS_CLK = ~SYS_CLK;	// 40 ns period

	task automatic report_mismatch(input string test, input logic [63:0] exp,
	                               input logic [63:0] act);
		$display("[FAIL] %s expected %h actual %h", test, exp, act);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		$display("ERROR: %s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	function automatic logic [15:0] swap_bytes(input logic [15:0] d);
		return {d[7:0], d[15:8]};
	endfunction

	// word offset within the DDR word picks the lane pair, offset 0 at the top
	function automatic logic [7:0] lane_pair_be(input logic [1:0] half);
		case (half)
			2'd0:    return 8'b1100_0000;
			2'd1:    return 8'b0011_0000;
			2'd2:    return 8'b0000_1100;
			default: return 8'b0000_0011;
		endcase
	endfunction

	// uw_n/lw_n pair i lands on lanes 2i+1 and 2i
	function automatic logic [7:0] dram_write_be(input logic [3:0] uw_n, input logic [3:0] lw_n);
		logic [7:0] be;
		for (int i = 0; i < 4; i++) begin
			be[2*i+1] = !uw_n[i];
			be[2*i]   = !lw_n[i];
		end
		return be;
	endfunction

	// ========================================================================
	// concurrent checks
	// ========================================================================
	assert property (@(posedge SYS_CLK) disable iff (reset)
		ddr_cmd.rd && ddr_rsp.busy |=> ddr_cmd.rd)
		else report_error("read request dropped while DDR was busy");
	assert property (@(posedge SYS_CLK) disable iff (reset)
		!core_hold && ddr_cmd.we && ddr_rsp.busy |=> ddr_cmd.we)
		else report_error("console write request dropped while DDR was busy");
	assert property (@(posedge SYS_CLK) disable iff (reset) core_hold |-> !ddr_cmd.rd)
		else report_error("read request issued during a ROM load");
	assert property (@(posedge SYS_CLK) disable iff (reset)
		ram_rdy && !core_dram.cas_n |=> ram_rdy)
		else report_error("ram_rdy fell before cas_n rose");
	assert property (@(posedge SYS_CLK) disable iff (reset)
		core_dram.cas_n |-> dram_oe == 4'b0000)
		else report_mismatch("dram_oe outside cas", 64'd0, 64'(dram_oe));
	assert property (@(posedge SYS_CLK) disable iff (reset)
		cart_oe == (cart.ce_n ? 2'b00 : ~cart.oe_n))
		else report_mismatch("cart_oe", {62'd0, (cart.ce_n ? 2'b00 : ~cart.oe_n)},
		                     64'(cart_oe));

	// ========================================================================
	// command monitor, sampled mid cycle
	// ========================================================================
	always @(negedge SYS_CLK) begin : cmd_mon
		logic [31:0] la;
		ddr_word_u   exp_w;
		if (!reset && core_hold && ddr_cmd.we) begin	// loader write
			if (load_seen >= load_words.size())
				report_error("loader write without a download strobe");
			la       = load_base_addr + 32'(2 * load_seen);
			exp_w.h  = {4{swap_bytes(load_words[load_seen])}};
			assert (ddr_cmd.addr == ddr_addr_w'(la[23:3]))
				else report_mismatch("load addr", 64'(la[23:3]), 64'(ddr_cmd.addr));
			assert (ddr_cmd.be == lane_pair_be(la[2:1]))
				else report_mismatch("load be", 64'(lane_pair_be(la[2:1])), 64'(ddr_cmd.be));
			assert (ddr_cmd.din == exp_w)
				else report_mismatch("load din", exp_w, ddr_cmd.din);
			load_seen++;
		end
		if (!reset && !core_hold && ddr_cmd.we && !ddr_rsp.busy) begin	// accepted next edge
			wr_accepts++;
			assert (ddr_cmd.addr == exp_addr)
				else report_mismatch("dram write addr", 64'(exp_addr), 64'(ddr_cmd.addr));
			assert (ddr_cmd.be == exp_be)
				else report_mismatch("dram write be", 64'(exp_be), 64'(ddr_cmd.be));
			assert (ddr_cmd.din == exp_din)
				else report_mismatch("dram write din", exp_din, ddr_cmd.din);
		end
		if (!reset && ddr_cmd.rd && !ddr_rsp.busy) begin
			rd_accepts++;
			assert (ddr_cmd.addr == exp_addr)
				else report_mismatch("read addr", 64'(exp_addr), 64'(ddr_cmd.addr));
			if (!cart.ce_n) begin	// cartridge reads fetch the whole word
				assert (ddr_cmd.be == 8'hff)
					else report_mismatch("cart read be", 64'hff, 64'(ddr_cmd.be));
			end
		end
	end

	// ========================================================================
	// stimulus tasks
	// ========================================================================
	task automatic load_image();
		logic [15:0] w;
		@(posedge SYS_CLK);
		load_in.download <= 1'b1;
		load_in.index    <= 8'd1;	// nonzero index means ROM image
		@(posedge SYS_CLK);
		for (int k = 0; k < n_load; k++) begin
			w = 16'($random(seed));
			load_words.push_back(w);
			@(posedge SYS_CLK);
			load_in.wr   <= 1'b1;
			load_in.data <= w;
			@(posedge SYS_CLK);
			load_in.wr <= 1'b0;
			@(negedge SYS_CLK);
			assert (core_hold) else report_error("console not held during ROM load");
			repeat (($random(seed) & 3)) @(posedge SYS_CLK);	// random gap
		end
		@(posedge SYS_CLK);
		load_in.download <= 1'b0;
		@(negedge SYS_CLK);
		assert (core_hold) else report_error("core_hold fell together with download");
		@(negedge SYS_CLK);
		assert (!core_hold) else report_error("core_hold high one cycle after download fell");
		assert (load_seen == n_load)
			else report_mismatch("load writes", 64'(n_load), 64'(load_seen));
		@(posedge SYS_CLK);
		load_in.index <= 8'd0;
	endtask

	task automatic dram_read(input logic [23:0] a, output logic [63:0] q);
		logic [3:0]  oe;
		logic [63:0] exp_q;
		oe = 4'($random(seed));
		if (oe == 4'hf)
			oe = 4'h0;
		@(posedge SYS_CLK);
		rd_accepts = 0;
		exp_addr   = ddr_addr_w'(a[23:3]);
		cart.addr       <= a;
		core_dram.fdram <= 1'b1;
		core_dram.oe_n  <= oe;
		core_dram.cas_n <= 1'b0;
		do @(negedge SYS_CLK); while (!ram_rdy);
		exp_q = mem_model.peek(exp_addr);
		assert (rd_accepts == 1) else report_mismatch("dram read requests", 64'd1, 64'(rd_accepts));
		assert (dram_q == exp_q) else report_mismatch("dram_q", exp_q, dram_q);
		assert (dram_oe == ~oe) else report_mismatch("dram_oe", {60'd0, ~oe}, 64'(dram_oe));
		q = dram_q;
		@(posedge SYS_CLK);
		core_dram.cas_n <= 1'b1;	// oe_n stays low one more cycle
		@(posedge SYS_CLK);
		core_dram.oe_n  <= 4'hf;
		@(negedge SYS_CLK);
		assert (!ram_rdy) else report_error("ram_rdy still high after cas_n rose");
	endtask

	task automatic cart_read(input logic [23:0] a);
		logic [1:0] oe;
		ddr_word_u  w;
		oe = 2'($random(seed));
		if (oe == 2'b11)
			oe = 2'b00;
		@(posedge SYS_CLK);
		rd_accepts = 0;
		exp_addr   = ddr_addr_w'(a[23:3]);
		cart.addr       <= a;
		cart.oe_n       <= oe;
		cart.ce_n       <= 1'b0;	// falling edge starts the cycle
		core_dram.fdram <= 1'b0;
		do @(negedge SYS_CLK); while (!ram_rdy);
		w = mem_model.peek(exp_addr);
		assert (rd_accepts == 1) else report_mismatch("cart read requests", 64'd1, 64'(rd_accepts));
		assert (cart_q == {4{w.b[a[2:0]]}})
			else report_mismatch("cart_q", 64'({4{w.b[a[2:0]]}}), 64'(cart_q));
		@(posedge SYS_CLK);
		cart.ce_n <= 1'b1;	// oe_n released a cycle after ce_n
		@(posedge SYS_CLK);
		cart.oe_n <= 2'b11;
	endtask

	task automatic dram_write(input logic [23:0] a);
		logic [3:0]  uw;
		logic [3:0]  lw;
		logic [63:0] d;
		uw = 4'($random(seed));
		lw = 4'($random(seed));
		if ({uw, lw} == 8'hff)
			lw = 4'h0;
		d = {$random(seed), $random(seed)};
		@(posedge SYS_CLK);
		wr_accepts = 0;
		exp_addr   = ddr_addr_w'(a[23:3]);
		exp_be     = dram_write_be(uw, lw);
		exp_din    = d;
		cart.addr       <= a;
		core_d          <= d;
		core_dram.fdram <= 1'b1;
		core_dram.uw_n  <= uw;
		core_dram.lw_n  <= lw;
		core_dram.cas_n <= 1'b0;
		do @(negedge SYS_CLK); while (!ram_rdy);
		assert (wr_accepts == 1) else report_mismatch("dram write requests", 64'd1, 64'(wr_accepts));
		repeat (2) @(negedge SYS_CLK);
		assert (ram_rdy) else report_error("ram_rdy not held while cas_n low");
		@(posedge SYS_CLK);
		core_dram.uw_n  <= 4'hf;
		core_dram.lw_n  <= 4'hf;
		core_dram.cas_n <= 1'b1;
		@(posedge SYS_CLK);
		@(negedge SYS_CLK);
		assert (!ram_rdy) else report_error("ram_rdy still high after cas_n rose");
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		logic [31:0] la;
		logic [63:0] q;
		ddr_word_u   rw;
		logic [23:0] wr_addrs [$];
		seed       = 32'he37fc3d2;
		reset      = 1'b1;
		load_in    = '0;
		core_dram  = {4'hf, 4'hf, 4'hf, 1'b1, 1'b0};	// oe, uw, lw off, cas high, cart
		core_d     = '0;
		cart       = {24'h000000, 1'b1, 2'b11};
		load_seen  = 0;
		rd_accepts = 0;
		wr_accepts = 0;
		exp_addr   = '0;
		exp_be     = '0;
		exp_din    = '0;
		repeat (4) @(posedge SYS_CLK);
		reset <= 1'b0;
		@(negedge SYS_CLK);
		assert (!ddr_cmd.rd && !ddr_cmd.we && !ram_rdy && !core_hold)
			else report_error("outputs not idle after reset");

		load_image();
		for (int k = 0; k < n_load; k++) begin	// loaded halves read back
			la = load_base_addr + 32'(2 * k);
			dram_read(la[23:0], q);
			rw = q;
			assert (rw.h[la[2:1]] == swap_bytes(load_words[k]))
				else report_mismatch("rom readback", 64'(swap_bytes(load_words[k])),
				                     64'(rw.h[la[2:1]]));
		end
		for (int i = 0; i < n_cart; i++)
			cart_read(24'($random(seed)));
		for (int i = 0; i < n_wr; i++) begin
			wr_addrs.push_back(24'($random(seed)));
			dram_write(wr_addrs[i]);
		end
		foreach (wr_addrs[i])
			dram_read(wr_addrs[i], q);

		@(negedge SYS_CLK);
		$display("Regression passed");
		$finish;
	end

	// watchdog, 40 cycles per transfer
	initial begin
		#(n_xfer * 40 * 40);
		report_error("watchdog timeout, the DUT stopped responding");
	end

endmodule

// ==== sim.f ====
rtl/jag_mem_pkg.sv
rtl/rom_loader.sv
rtl/dram_sequencer.sv
rtl/ddr_port_mux.sv
rtl/jag_ddr_bridge.sv
verification/ddr_mem_model.sv
verification/jag_ddr_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: jag_ddr_bridge

sources:
  - files:
      - rtl/jag_mem_pkg.sv
      - rtl/rom_loader.sv
      - rtl/dram_sequencer.sv
      - rtl/ddr_port_mux.sv
      - rtl/jag_ddr_bridge.sv
  - target: simulation
    files:
      - verification/ddr_mem_model.sv
      - verification/jag_ddr_bridge_tb.sv
